//--- tlbProj.f
verilog/sv32Pkg.sv
verilog/privPkg.sv
verilog/tlbCam.sv
verilog/tlbRam.sv
verilog/tlbLru.sv
verilog/tlb.sv
verilog/tlbTop.sv
testbench/tlbTb.sv

//--- Makefile
# Verilator build and run for the TLB testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tlbTb
FILELIST  ?= tlbProj.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "sim passed" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tlbTb.sv
/* Self-checking testbench for the instruction and data TLB pair
   Drives lookups, fills and flushes and checks each cycle against a reference model */
`timescale 1ns/1ps

module tlbTb;
  import sv32Pkg::*;
  import privPkg::*;

  localparam int clkPeriod    = 100;
  localparam int instrSide    = 0;
  localparam int dataSide     = 1;
  localparam int bareLoops    = 21;
  localparam int permLoops    = 60;
  localparam int replacePages = 12;
  // Reset, the bare sweep, fill steps, permission pairs, replacement and flush
  localparam int testCycles   = 2 + bareLoops + 20 + 2 * permLoops + 3 * replacePages + 20;
  localparam int marginCycles = 100;

  logic        clk;
  logic        rstN;
  logic [31:0] satp;
  statusT      status;
  privModeT    privilegeMode;
  logic        disableTranslation;
  tlbWriteT    pteWrite;
  logic        tlbFlush;
  logic [31:0] instrAddress;
  logic        instrFetch;
  logic        itlbWrite;
  logic [31:0] dataAddress;
  accessT      dataAccess;
  logic        dtlbWrite;
  tlbResultT   instrResult;
  tlbResultT   dataResult;

  // Reference state for both TLBs, indexed by side
  logic [tlbEntries-1:0] modelValid [2];
  logic [tlbEntries-1:0] modelUsed  [2];
  vpnT                   modelTag   [2][tlbEntries];
  pageTypeT              modelType  [2][tlbEntries];
  pteT                   modelPte   [2][tlbEntries];
  string                 testName;

  tlbTop tlbTop_inst (
    .clk                (clk),
    .rstN               (rstN),
    .satp               (satp),
    .status             (status),
    .privilegeMode      (privilegeMode),
    .disableTranslation (disableTranslation),
    .pteWrite           (pteWrite),
    .tlbFlush           (tlbFlush),
    .instrAddress       (instrAddress),
    .instrFetch         (instrFetch),
    .itlbWrite          (itlbWrite),
    .dataAddress        (dataAddress),
    .dataAccess         (dataAccess),
    .dtlbWrite          (dtlbWrite),
    .instrResult        (instrResult),
    .dataResult         (dataResult)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Megapage entries ignore the lower page number segment
  function automatic logic [tlbEntries-1:0] modelMatch(int side, logic [31:0] addr);
    logic [tlbEntries-1:0] lines;
    vpnT                   vpn;
    vpn = addr[31:12];
    for (int i = 0; i < tlbEntries; i++) begin
      lines[i] = modelValid[side][i] && (modelTag[side][i].vpn1 == vpn.vpn1)
               && ((modelType[side][i] == megaPage) || (modelTag[side][i].vpn0 == vpn.vpn0));
    end
    return lines;
  endfunction

  // Lowest empty entry first, then the lowest one not recently used
  function automatic int modelVictim(int side);
    int victim;
    victim = -1;
    for (int i = 0; i < tlbEntries; i++) begin
      if (victim < 0 && !modelValid[side][i]) victim = i;
    end
    for (int i = 0; i < tlbEntries; i++) begin
      if (victim < 0 && !modelUsed[side][i]) victim = i;
    end
    return (victim < 0) ? 0 : victim;
  endfunction

  function automatic tlbResultT expectedResult(int side, logic [31:0] addr, accessT acc);
    logic [tlbEntries-1:0] lines;
    pteT                   pte;
    pageTypeT              pageType;
    privModeT              mode;
    logic                  translate;
    logic                  fault;
    tlbResultT             res;
    lines    = modelMatch(side, addr);
    pte      = '0;
    pageType = kiloPage;
    for (int i = 0; i < tlbEntries; i++) begin
      if (lines[i]) begin
        pte      = modelPte[side][i];
        pageType = modelType[side][i];
      end
    end
    // Only the data side looks at MPRV
    mode = (side == dataSide && status.mprv) ? status.mpp : privilegeMode;
    translate = satp[31] && (mode != machineMode) && !disableTranslation;
    res.hit  = (|lines) && (acc.read || acc.write);
    res.miss = !res.hit && !tlbFlush && translate && (acc.read || acc.write);
    if (side == instrSide) begin
      fault = ((mode == userMode) && !pte.u) || ((mode == supervisorMode) && pte.u) || !pte.x;
    end else begin
      fault = ((mode == userMode) && !pte.u)
           || ((mode == supervisorMode) && pte.u && !status.sum)
           || (acc.read && !pte.r && !(status.mxr && pte.x))
           || (acc.write && !pte.w);
    end
    res.pageFault = translate && res.hit && fault;
    if (!translate) begin
      res.physicalAddress = {2'b00, addr};
    end else if (res.hit) begin
      res.physicalAddress = {pte.ppn.ppn1,
                             (pageType == megaPage) ? addr[21:12] : pte.ppn.ppn0, addr[11:0]};
    end else begin
      res.physicalAddress = '0;
    end
    return res;
  endfunction

  // Applies what the coming clock edge does to one side
  task automatic advanceModel(int side, logic [31:0] addr, accessT acc, logic write);
    logic [tlbEntries-1:0] touched;
    logic [tlbEntries-1:0] usedNext;
    int                    victim;
    victim  = modelVictim(side);
    touched = modelMatch(side, addr) & {tlbEntries{acc.read | acc.write}};
    if (write) touched[victim] = 1'b1;
    usedNext = modelUsed[side] | touched;
    modelUsed[side] = (&usedNext) ? touched : usedNext;
    if (write) begin
      modelTag[side][victim]   = addr[31:12];
      modelType[side][victim]  = pteWrite.pageType;
      modelPte[side][victim]   = pteWrite.pte;
      modelValid[side][victim] = 1'b1;
    end
    if (tlbFlush) modelValid[side] = '0;
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic compareValue(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      $display("Error: test %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic checkCycle();
    accessT fetchAccess;
    fetchAccess.read  = instrFetch;
    fetchAccess.write = 1'b0;
    if (!rstN) begin
      for (int s = 0; s < 2; s++) begin
        modelValid[s] = '0;
        modelUsed[s]  = '0;
      end
    end else begin
      compareValue({testName, " itlb"},
                   64'(expectedResult(instrSide, instrAddress, fetchAccess)), 64'(instrResult));
      compareValue({testName, " dtlb"},
                   64'(expectedResult(dataSide, dataAddress, dataAccess)), 64'(dataResult));
      advanceModel(instrSide, instrAddress, fetchAccess, itlbWrite);
      advanceModel(dataSide, dataAddress, dataAccess, dtlbWrite);
    end
  endtask

  // Outputs are sampled just before each rising edge
  initial begin
    forever begin
      @(posedge clk);
      #(clkPeriod - 5);
      checkCycle();
    end
  end

  initial begin
    #((testCycles + marginCycles) * clkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", testCycles + marginCycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic nextCycle();
    @(posedge clk);
    #5;
  endtask

  task automatic setPage(logic [31:0] addr);
    instrAddress = addr;
    dataAddress  = addr;
  endtask

  // The tag comes from the address held during the fill cycle
  task automatic fillBoth(logic [31:0] addr, pteT pte, pageTypeT pageType);
    setPage(addr);
    pteWrite.pte      = pte;
    pteWrite.pageType = pageType;
    itlbWrite = 1'b1;
    dtlbWrite = 1'b1;
    nextCycle();
    itlbWrite = 1'b0;
    dtlbWrite = 1'b0;
  endtask

  function automatic privModeT randomMode();
    case ($urandom_range(0, 2))
      0:       return userMode;
      1:       return supervisorMode;
      default: return machineMode;
    endcase
  endfunction

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    logic [31:0] addr;
    logic [31:0] replaceAddr [replacePages];
    pteT         pte;
    void'($urandom(32'h5f6c_1357));
    clk = 1'b0;
    rstN = 1'b0;
    satp = '0;
    status = '0;
    privilegeMode = machineMode;
    disableTranslation = 1'b0;
    pteWrite = '0;
    tlbFlush = 1'b0;
    instrAddress = '0;
    instrFetch = 1'b0;
    itlbWrite = 1'b0;
    dataAddress = '0;
    dataAccess = '0;
    dtlbWrite = 1'b0;
    testName = "reset";
    repeat (2) @(posedge clk);
    #5;
    rstN = 1'b1;

    // Bare mode, machine mode and disabled translation rotate each cycle
    testName = "bare";
    for (int k = 0; k < bareLoops; k++) begin
      satp = {(k % 3) != 0, 31'($urandom())};
      status = (k % 3 == 1) ? statusT'(0) : statusT'($urandom_range(0, 31));
      privilegeMode = (k % 3 == 1) ? machineMode : supervisorMode;
      disableTranslation = (k % 3 == 2);
      instrAddress = $urandom();
      dataAddress = $urandom();
      instrFetch = 1'($urandom_range(0, 1));
      dataAccess = accessT'($urandom_range(0, 3));
      nextCycle();
    end

    testName = "missFill";
    satp = 32'h8000_0000;
    status = '0;
    privilegeMode = supervisorMode;
    disableTranslation = 1'b0;
    instrFetch = 1'b1;
    dataAccess = '{read: 1'b1, write: 1'b0};
    setPage(32'h0040_3abc);
    nextCycle();
    pte = '0;
    pte.ppn = '{ppn1: 12'h3c5, ppn0: 10'h2a7};
    {pte.d, pte.a, pte.x, pte.w, pte.r, pte.v} = 6'b111111;
    fillBoth(32'h0040_3abc, pte, kiloPage);
    nextCycle();
    addr = {10'd2, 10'($urandom()), 12'($urandom())};
    setPage(addr);
    nextCycle();
    pte.ppn = '{ppn1: 12'h81f, ppn0: 10'h155};
    fillBoth(addr, pte, megaPage);
    for (int k = 0; k < 8; k++) begin
      setPage({10'd2, 10'($urandom()), 12'($urandom())});
      nextCycle();
    end

    // Each pair fills a fresh page and then looks it up with random modes
    testName = "permission";
    for (int k = 0; k < permLoops; k++) begin
      privilegeMode = randomMode();
      status.mxr = 1'($urandom_range(0, 1));
      status.sum = 1'($urandom_range(0, 1));
      status.mprv = 1'($urandom_range(0, 1));
      status.mpp = randomMode();
      addr = {10'h100 + 10'(k), 10'($urandom()), 12'($urandom())};
      fillBoth(addr, pteT'($urandom()), pageTypeT'($urandom_range(0, 1)));
      instrFetch = 1'($urandom_range(0, 1));
      dataAccess = accessT'($urandom_range(0, 3));
      nextCycle();
    end

    testName = "replace";
    privilegeMode = supervisorMode;
    status = '0;
    instrFetch = 1'b1;
    dataAccess = '{read: 1'b1, write: 1'b0};
    for (int k = 0; k < replacePages; k++) begin
      replaceAddr[k] = {10'h200 + 10'(k), 10'(k * 7), 12'h0};
      fillBoth(replaceAddr[k], pteT'($urandom()), kiloPage);
      setPage(replaceAddr[$urandom_range(0, k)]);
      nextCycle();
    end
    for (int k = 0; k < replacePages; k++) begin
      setPage(replaceAddr[k]);
      nextCycle();
    end

    testName = "flush";
    setPage(replaceAddr[replacePages - 1]);
    nextCycle();
    tlbFlush = 1'b1;
    nextCycle();
    tlbFlush = 1'b0;
    for (int k = 0; k < replacePages; k++) begin
      setPage(replaceAddr[k]);
      nextCycle();
    end
    // A fill that meets a flush must not survive it
    tlbFlush = 1'b1;
    fillBoth(32'h1234_5678, pteT'($urandom()), kiloPage);
    tlbFlush = 1'b0;
    nextCycle();
    nextCycle();

    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog/tlbTop.sv
/* Instruction and data TLB pair sharing satp, status, privilege, fill data and flush
   Each side takes its own address, access and fill strobe and returns its own result */
`timescale 1ns/1ps

module tlbTop (
  input  logic               clk,
  input  logic               rstN,
  input  logic [31:0]        satp,
  input  privPkg::statusT    status,
  input  privPkg::privModeT  privilegeMode,
  input  logic               disableTranslation,
  input  sv32Pkg::tlbWriteT  pteWrite,
  input  logic               tlbFlush,
  input  logic [31:0]        instrAddress,
  input  logic               instrFetch,
  input  logic               itlbWrite,
  input  logic [31:0]        dataAddress,
  input  privPkg::accessT    dataAccess,
  input  logic               dtlbWrite,
  output sv32Pkg::tlbResultT instrResult,
  output sv32Pkg::tlbResultT dataResult
);
  import privPkg::*;

  // A fetch looks like a read and never a write
  accessT instrAccess;

  assign instrAccess.read  = instrFetch;
  assign instrAccess.write = 1'b0;

  ////////////////////////////////////////
  // Instruction side
  ////////////////////////////////////////

  tlb #(.itlb(1)) instrTlb (
    .clk                (clk),
    .rstN               (rstN),
    .satp               (satp),
    .status             (status),
    .privilegeMode      (privilegeMode),
    .disableTranslation (disableTranslation),
    .virtualAddress     (instrAddress),
    .access             (instrAccess),
    .tlbWrite           (itlbWrite),
    .pteWrite           (pteWrite),
    .flush              (tlbFlush),
    .result             (instrResult)
  );

  ////////////////////////////////////////
  // Data side
  ////////////////////////////////////////

  tlb #(.itlb(0)) dataTlb (
    .clk                (clk),
    .rstN               (rstN),
    .satp               (satp),
    .status             (status),
    .privilegeMode      (privilegeMode),
    .disableTranslation (disableTranslation),
    .virtualAddress     (dataAddress),
    .access             (dataAccess),
    .tlbWrite           (dtlbWrite),
    .pteWrite           (pteWrite),
    .flush              (tlbFlush),
    .result             (dataResult)
  );

endmodule

//--- verilog/tlb.sv
/* One Sv32 TLB with combinational lookup, permission checks and superpage mixing
   Set itlb to 1 for instruction fetches and to 0 for loads and stores */
`timescale 1ns/1ps

module tlb #(
  parameter int itlb = 0
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic [31:0]        satp,
  input  privPkg::statusT    status,
  input  privPkg::privModeT  privilegeMode,
  input  logic               disableTranslation,
  input  logic [31:0]        virtualAddress,
  input  privPkg::accessT    access,
  input  logic               tlbWrite,
  input  sv32Pkg::tlbWriteT  pteWrite,
  input  logic               flush,
  output sv32Pkg::tlbResultT result
);
  import sv32Pkg::*;
  import privPkg::*;

  logic                    translate;
  logic                    anyAccess;
  logic                    hit;
  privModeT                effectiveMode;
  vpnT                     vpn;
  logic [11:0]             pageOffset;
  logic [tlbIndexBits-1:0] writeIndex;
  logic [tlbEntries-1:0]   writeMask;
  logic [tlbEntries-1:0]   validLines;
  logic [tlbEntries-1:0]   matchLines;
  pageTypeT                hitPageType;
  pteT                     matchedPte;
  ppnT                     mixedPpn;
  logic                    permissionFault;

  assign vpn        = virtualAddress[31:12];
  assign pageOffset = virtualAddress[11:0];
  assign anyAccess  = access.read | access.write;

  // Paging applies only in Sv32 mode below machine level
  assign translate = (satp[31] == satpModeSv32) && (effectiveMode != machineMode)
                   && !disableTranslation;

  // Fills go to the entry picked by the replacement policy
  assign writeMask = ({{(tlbEntries-1){1'b0}}, tlbWrite} << writeIndex);

  ////////////////////////////////////////
  // Storage and replacement
  ////////////////////////////////////////

  tlbCam cam (
    .clk           (clk),
    .rstN          (rstN),
    .vpn           (vpn),
    .writeMask     (writeMask),
    .writePageType (pteWrite.pageType),
    .flush         (flush),
    .valid         (validLines),
    .matchLines    (matchLines),
    .hitPageType   (hitPageType)
  );

  tlbRam ram (
    .clk        (clk),
    .rstN       (rstN),
    .writeMask  (writeMask),
    .writePte   (pteWrite.pte),
    .matchLines (matchLines),
    .matchedPte (matchedPte)
  );

  // A match only counts as a use when something is actually accessed
  tlbLru lru (
    .clk        (clk),
    .rstN       (rstN),
    .usedLines  (matchLines & {tlbEntries{anyAccess}}),
    .write      (tlbWrite),
    .valid      (validLines),
    .writeIndex (writeIndex)
  );

  ////////////////////////////////////////
  // Permission checks
  ////////////////////////////////////////

  if (itlb == 1) begin : gInstrCheck
    // Fetches always run at the current privilege, MPRV has no effect
    assign effectiveMode = privilegeMode;
    // User code runs only from u pages and supervisor code never does
    assign permissionFault = ((effectiveMode == userMode) && !matchedPte.u)
                          || ((effectiveMode == supervisorMode) && matchedPte.u)
                          || !matchedPte.x;
  end else begin : gDataCheck
    logic improperPrivilege;
    logic invalidRead;
    logic invalidWrite;

    // With MPRV set, loads and stores are checked at the MPP level
    assign effectiveMode = status.mprv ? status.mpp : privilegeMode;
    assign improperPrivilege = ((effectiveMode == userMode) && !matchedPte.u)
                            || ((effectiveMode == supervisorMode) && matchedPte.u && !status.sum);
    // MXR lets an executable page be read even without its r bit
    assign invalidRead  = access.read && !matchedPte.r && !(status.mxr && matchedPte.x);
    assign invalidWrite = access.write && !matchedPte.w;
    assign permissionFault = improperPrivilege || invalidRead || invalidWrite;
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  // A megapage keeps the lower virtual segment as part of its offset
  assign mixedPpn.ppn1 = matchedPte.ppn.ppn1;
  assign mixedPpn.ppn0 = (hitPageType == megaPage) ? vpn.vpn0 : matchedPte.ppn.ppn0;

  assign hit = (|matchLines) && anyAccess;

  // Translating without a hit gives zero so a bad address is easy to spot
  assign result.physicalAddress = !translate ? {2'b00, virtualAddress}
                                : hit        ? {mixedPpn, pageOffset}
                                :              '0;
  assign result.hit  = hit;
  // No miss is raised while the entries are being flushed
  assign result.miss = !hit && !flush && translate && anyAccess;
  assign result.pageFault = translate && hit && permissionFault;

endmodule

//--- verilog/tlbLru.sv
/* Not-recently-used replacement for one TLB
   Tracks a used bit per entry and names the entry the next fill replaces */
`timescale 1ns/1ps

module tlbLru (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [sv32Pkg::tlbEntries-1:0]   usedLines,
  input  logic                             write,
  input  logic [sv32Pkg::tlbEntries-1:0]   valid,
  output logic [sv32Pkg::tlbIndexBits-1:0] writeIndex
);
  import sv32Pkg::*;

  logic [tlbEntries-1:0] usedBits;
  logic [tlbEntries-1:0] touchedLines;
  logic [tlbEntries-1:0] usedNext;

  // Entries touched this cycle are the hit entry and the one being filled
  assign touchedLines = usedLines | ({{(tlbEntries-1){1'b0}}, write} << writeIndex);

  // Once every bit would be set, only this cycle's entries stay marked
  always_comb begin
    usedNext = usedBits | touchedLines;
    if (&usedNext) begin
      usedNext = touchedLines;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      usedBits <= '0;
    end else begin
      usedBits <= usedNext;
    end
  end

  ////////////////////////////////////////
  // Victim choice
  ////////////////////////////////////////

  // Scanning downwards leaves the lowest candidate in writeIndex
  // An empty entry is preferred over any unused valid one
  always_comb begin
    writeIndex = '0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (!usedBits[i]) writeIndex = tlbIndexBits'(i);
    end
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (!valid[i]) writeIndex = tlbIndexBits'(i);
    end
  end

endmodule

//--- verilog/tlbRam.sv
/* PTE side of a TLB with one stored entry per tag
   Returns the PTE of whichever entry the tag side matched */
`timescale 1ns/1ps

module tlbRam (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic [sv32Pkg::tlbEntries-1:0] writeMask,
  input  sv32Pkg::pteT                   writePte,
  input  logic [sv32Pkg::tlbEntries-1:0] matchLines,
  output sv32Pkg::pteT                   matchedPte
);
  import sv32Pkg::*;

  pteT pteStore [tlbEntries];

  // Each fill writes the PTE into the entry chosen by the write mask
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < tlbEntries; i++) begin
        pteStore[i] <= '0;
      end
    end else begin
      for (int i = 0; i < tlbEntries; i++) begin
        if (writeMask[i]) begin
          pteStore[i] <= writePte;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read out
  ////////////////////////////////////////

  // AND-OR mux driven directly by the one-hot match lines
  // With no match the result stays all zero
  always_comb begin
    matchedPte = '0;
    for (int i = 0; i < tlbEntries; i++) begin
      matchedPte = matchedPte | (pteStore[i] & {$bits(pteT){matchLines[i]}});
    end
  end

endmodule

//--- verilog/tlbCam.sv
/* Tag side of a TLB holding valid bits, virtual page tags and page types
   Produces one-hot match lines for the current virtual page number */
`timescale 1ns/1ps

module tlbCam (
  input  logic                           clk,
  input  logic                           rstN,
  input  sv32Pkg::vpnT                   vpn,
  input  logic [sv32Pkg::tlbEntries-1:0] writeMask,
  input  sv32Pkg::pageTypeT              writePageType,
  input  logic                           flush,
  output logic [sv32Pkg::tlbEntries-1:0] valid,
  output logic [sv32Pkg::tlbEntries-1:0] matchLines,
  output sv32Pkg::pageTypeT              hitPageType
);
  import sv32Pkg::*;

  // Tag and page size of every entry
  vpnT      tagStore  [tlbEntries];
  pageTypeT typeStore [tlbEntries];

  ////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////

  // A flush empties the whole TLB and wins over a write in the same cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= '0;
    end else if (flush) begin
      valid <= '0;
    end else begin
      valid <= valid | writeMask;
    end
  end

  ////////////////////////////////////////
  // Tag store
  ////////////////////////////////////////

  // The tag is the page the requester is still holding when the fill arrives
  always_ff @(posedge clk) begin
    for (int i = 0; i < tlbEntries; i++) begin
      if (writeMask[i]) begin
        tagStore[i]  <= vpn;
        typeStore[i] <= writePageType;
      end
    end
  end

  ////////////////////////////////////////
  // Match lines
  ////////////////////////////////////////

  always_comb begin
    matchLines  = '0;
    hitPageType = kiloPage;
    for (int i = 0; i < tlbEntries; i++) begin
      // The upper segment must always agree
      // The lower segment only counts for 4 KiB pages
      matchLines[i] = valid[i]
                    && (tagStore[i].vpn1 == vpn.vpn1)
                    && ((typeStore[i] != kiloPage) || (tagStore[i].vpn0 == vpn.vpn0));
      // Only one entry should match, so an OR picks its page type
      hitPageType = hitPageType | (matchLines[i] & typeStore[i]);
    end
  end

endmodule

//--- verilog/privPkg.sv
/* Privilege modes, satp mode encoding, status bits and access kinds
   Used by the TLBs to decide whether and how a lookup is checked */
package privPkg;

  ////////////////////////////////////////
  // Privilege
  ////////////////////////////////////////

  typedef logic [1:0] privModeT;

  localparam privModeT userMode       = 2'b00;
  localparam privModeT supervisorMode = 2'b01;
  localparam privModeT machineMode    = 2'b11;

  // Value of satp bit 31 that turns Sv32 paging on
  // Zero leaves the hart in bare mode without translation
  localparam logic satpModeSv32 = 1'b1;

  // The mstatus fields that change how data accesses are checked
  typedef struct packed {
    logic     mxr;
    logic     sum;
    logic     mprv;
    privModeT mpp;
  } statusT;

  ////////////////////////////////////////
  // Access kinds
  ////////////////////////////////////////

  // An instruction fetch is presented as a read
  typedef struct packed {
    logic read;
    logic write;
  } accessT;

endpackage

//--- verilog/sv32Pkg.sv
/* Sv32 address, page number and page table entry formats shared by the TLB blocks
   Also fixes the number of TLB entries and the request and result records */
package sv32Pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Each TLB holds this many fully associative entries
  localparam int tlbEntries = 8;
  localparam int tlbIndexBits = 3;

  // Sv32 produces a 34 bit physical address from a 32 bit virtual one
  localparam int paBits = 34;

  ////////////////////////////////////////
  // Address and entry formats
  ////////////////////////////////////////

  // Virtual page number split into its two table levels
  typedef struct packed {
    logic [9:0] vpn1;
    logic [9:0] vpn0;
  } vpnT;

  // Physical page number, whose upper segment is wider than in the virtual one
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
  } ppnT;

  // A zero page type is a 4 KiB page and a one is a 4 MiB megapage
  typedef logic pageTypeT;
  localparam pageTypeT kiloPage = 1'b0;
  localparam pageTypeT megaPage = 1'b1;

  // Leaf page table entry as it sits in memory
  typedef struct packed {
    ppnT        ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pteT;

  // New entry handed in by the walker, together with the level it was found at
  typedef struct packed {
    pteT      pte;
    pageTypeT pageType;
  } tlbWriteT;

  // Everything a lookup reports back to the pipeline
  typedef struct packed {
    logic [paBits-1:0] physicalAddress;
    logic              hit;
    logic              miss;
    logic              pageFault;
  } tlbResultT;

endpackage
